// File: design/secure_alu_pkg.sv
// Secure ALU shared definitions
`default_nettype none

package secure_alu_pkg;

	// Datapath widths
	localparam int DATA_W = 32;	// Operand A and B
	localparam int RES_W = 64;	// Full product fits
	localparam int OP_W = 8;

	// Memory geometry, one bank per window
	localparam int MEM_AW = 8;	// Index bits per bank
	localparam int MEM_DEPTH = 256;
	localparam logic [DATA_W-1:0] LOW_LIMIT = 32'h0000_00FF;	// Last word of lower window
	localparam logic [DATA_W-1:0] HIGH_BASE = 32'hFFFF_FF00;	// First word of upper window

	// ALU opcodes
	localparam logic [OP_W-1:0] OP_ADD = 8'h00;
	localparam logic [OP_W-1:0] OP_SUB = 8'h01;
	localparam logic [OP_W-1:0] OP_MUL = 8'h02;
	localparam logic [OP_W-1:0] OP_AND = 8'h03;
	localparam logic [OP_W-1:0] OP_OR = 8'h04;
	localparam logic [OP_W-1:0] OP_XOR = 8'h05;	// Last arithmetic opcode
	localparam logic [OP_W-1:0] OP_NOT = 8'h06;	// Private only
	localparam logic [OP_W-1:0] OP_NOR = 8'h08;
	localparam logic [OP_W-1:0] OP_NAND = 8'h09;

	// Window select field of a memory opcode
	localparam logic [1:0] PSEL_LOWER = 2'b00;
	localparam logic [1:0] PSEL_UPPER = 2'b11;

	// Operation classes
	localparam int CLS_W = 3;
	localparam logic [CLS_W-1:0] CLS_ARITH = 3'd0;
	localparam logic [CLS_W-1:0] CLS_ILLEGAL = 3'd1;
	localparam logic [CLS_W-1:0] CLS_MEMORY = 3'd2;	// Public load/store
	localparam logic [CLS_W-1:0] CLS_PRIVATE = 3'd3;
	localparam logic [CLS_W-1:0] CLS_PMEMORY = 3'd4;	// Protected load/store

	// Error vector
	localparam int ERR_W = 2;
	localparam int ERR_ILLEGAL = 0;
	localparam int ERR_ACCESS = 1;

	// Sequencer states
	localparam int ST_W = 3;
	localparam logic [ST_W-1:0] ST_IDLE = 3'd0;
	localparam logic [ST_W-1:0] ST_DECODE = 3'd1;
	localparam logic [ST_W-1:0] ST_ACCESS = 3'd2;
	localparam logic [ST_W-1:0] ST_EXEC = 3'd3;
	localparam logic [ST_W-1:0] ST_RESULT = 3'd4;
	localparam logic [ST_W-1:0] ST_DONE = 3'd5;

	// Opcode byte, seen by the ALU or by the memory path
	typedef union packed {
		logic [OP_W-1:0] alu_op;	// Whole byte
		struct packed {
			logic [4:0] spare;	// Zero for every memory opcode
			logic [1:0] protected_sel;	// 11 selects the upper window
			logic write;	// Store when set
		} mem;
	} op_word_u;

endpackage

`default_nettype wire

// File: design/op_decoder.sv
// Operation class decoder
`timescale 1ns/1ps
`default_nettype none

module op_decoder
	import secure_alu_pkg::*;
(
	input  op_word_u         op_word,	// Captured opcode
	input  logic             sv,	// Supervisor mode
	input  logic             op_pf,	// Opcode prefix
	output logic [CLS_W-1:0] op_class
);

	// Pure lookup on the mode bits, no state
	always_comb begin
		op_class = CLS_ILLEGAL;	// Anything unmatched
		case ({sv, op_pf})
			2'b00: begin
				// Plain arithmetic and logic
				if (op_word.alu_op <= OP_XOR)
					op_class = CLS_ARITH;
			end
			2'b01: begin
				// Loads and stores, window picked by the select field
				if (op_word.mem.spare == '0) begin
					if (op_word.mem.protected_sel == PSEL_LOWER)
						op_class = CLS_MEMORY;	// 00, 01
					else if (op_word.mem.protected_sel == PSEL_UPPER)
						op_class = CLS_PMEMORY;	// 06, 07
				end
			end
			2'b11: begin
				// Private read-modify ops
				case (op_word.alu_op)
					OP_NOT, OP_NOR, OP_NAND: op_class = CLS_PRIVATE;
					default: op_class = CLS_ILLEGAL;	// 07 divide is gone
				endcase
			end
			default: op_class = CLS_ILLEGAL;	// sv without prefix
		endcase
	end

endmodule

`default_nettype wire

// File: design/access_ctrl.sv
// Memory window check
`timescale 1ns/1ps
`default_nettype none

module access_ctrl
	import secure_alu_pkg::*;
(
	input  logic              access_en,	// One-cycle pulse from sequencer
	input  logic [CLS_W-1:0]  op_class,
	input  op_word_u          op_word,
	input  logic [DATA_W-1:0] addr,
	output logic              mem_we,
	output logic              mem_re,
	output logic              access_err
);

	logic in_low;	// Address inside lower window
	logic in_high;	// Address inside upper window
	logic mem_cls;	// Public or protected load/store
	logic priv_cls;
	logic win_ok;

	assign in_low = (addr <= LOW_LIMIT);
	assign in_high = (addr >= HIGH_BASE);

	// Only these classes touch memory
	assign mem_cls = access_en && (op_class == CLS_MEMORY || op_class == CLS_PMEMORY);
	assign priv_cls = access_en && (op_class == CLS_PRIVATE);

	// Window rule
	always_comb begin
		if (priv_cls)
			win_ok = in_low || in_high;	// Private may read either bank
		else if (op_word.mem.protected_sel == PSEL_UPPER)
			win_ok = in_high;
		else
			win_ok = in_low;
	end

	// At most one strobe; a bad address raises the error instead
	assign mem_we = mem_cls && win_ok && op_word.mem.write;
	assign mem_re = (mem_cls && win_ok && !op_word.mem.write) ||
		(priv_cls && win_ok);	// Private always reads
	assign access_err = (mem_cls || priv_cls) && !win_ok;

endmodule

`default_nettype wire

// File: design/banked_mem.sv
// Two-bank data memory
`timescale 1ns/1ps
`default_nettype none

module banked_mem
	import secure_alu_pkg::*;
(
	input  logic              clk,
	input  logic              we,
	input  logic              re,
	input  logic [DATA_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata	// Registered, valid one edge after re
);

	logic [DATA_W-1:0] low_mem [MEM_DEPTH];	// Lower window words
	logic [DATA_W-1:0] high_mem [MEM_DEPTH];	// Upper window words
	logic [MEM_AW-1:0] idx;
	logic              hi_bank;

	// Window already checked upstream, so top bit picks the bank
	assign hi_bank = addr[DATA_W-1];
	assign idx = addr[MEM_AW-1:0];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			if (hi_bank)
				high_mem[idx] <= wdata;
			else
				low_mem[idx] <= wdata;
		end
	end

	// Read port, holds last word between reads
	always_ff @(posedge clk) begin
		if (re) begin
			if (hi_bank)
				rdata <= high_mem[idx];
			else
				rdata <= low_mem[idx];
		end
	end

endmodule

`default_nettype wire

// File: design/alu_core.sv
// Registered 64-bit ALU
`timescale 1ns/1ps
`default_nettype none

module alu_core
	import secure_alu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic              exec,	// Compute strobe, one cycle
	input  op_word_u          op_word,
	input  logic [DATA_W-1:0] x,	// Operand A or memory word
	input  logic [DATA_W-1:0] y,	// Operand B
	output logic [RES_W-1:0]  res
);

	logic [RES_W-1:0] x_ext;
	logic [RES_W-1:0] y_ext;

	// Zero extension for the wide arithmetic
	assign x_ext = {{(RES_W-DATA_W){1'b0}}, x};
	assign y_ext = {{(RES_W-DATA_W){1'b0}}, y};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			res <= '0;
		end else if (exec) begin
			case (op_word.alu_op)
				OP_ADD:  res <= x_ext + y_ext;	// Carry lands in bit 32
				OP_SUB:  res <= x_ext - y_ext;	// Wraps modulo 2^64
				OP_MUL:  res <= x_ext * y_ext;
				// Logic ops stay 32 bits wide
				OP_AND:  res <= {{(RES_W-DATA_W){1'b0}}, x & y};
				OP_OR:   res <= {{(RES_W-DATA_W){1'b0}}, x | y};
				OP_XOR:  res <= {{(RES_W-DATA_W){1'b0}}, x ^ y};
				OP_NOT:  res <= {{(RES_W-DATA_W){1'b0}}, ~x};	// y unused here
				OP_NOR:  res <= {{(RES_W-DATA_W){1'b0}}, ~(x | y)};
				OP_NAND: res <= {{(RES_W-DATA_W){1'b0}}, ~(x & y)};
				default: res <= '0;	// Store opcodes and the like
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/op_sequencer.sv
// Operation sequencer FSM
`timescale 1ns/1ps
`default_nettype none

module op_sequencer
	import secure_alu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic              start,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  op_word_u          op,
	input  logic              sv,
	input  logic              op_pf,
	input  logic [CLS_W-1:0]  op_class,	// From decoder
	input  logic              access_err,	// From window check
	input  logic [DATA_W-1:0] rdata,
	input  logic [RES_W-1:0]  alu_res,
	output op_word_u          op_word_q,
	output logic              sv_q,
	output logic              op_pf_q,
	output logic [DATA_W-1:0] addr,	// Captured A
	output logic [DATA_W-1:0] wdata,	// Captured B
	output logic              access_en,
	output logic              exec,
	output logic [DATA_W-1:0] alu_x,
	output logic              done,
	output logic [RES_W-1:0]  result,
	output logic [ERR_W-1:0]  err
);

	logic [ST_W-1:0]  state;
	logic             accept;	// Start taken this edge
	logic             acc_err_q;	// Window error held past ACCESS
	logic [RES_W-1:0] next_result;
	logic [ERR_W-1:0] next_err;

	// DONE also takes a start so back-to-back runs lose no cycle
	assign accept = start && (state == ST_IDLE || state == ST_DONE);

	// Operand capture
	always_ff @(posedge clk) begin
		if (accept) begin
			addr <= a;
			wdata <= b;
			op_word_q <= op;
			sv_q <= sv;
			op_pf_q <= op_pf;
		end
	end

	// Private ops work on the fetched word
	assign alu_x = (op_class == CLS_PRIVATE) ? rdata : addr;

	// Result source select
	always_comb begin
		next_err = '0;
		next_err[ERR_ILLEGAL] = (op_class == CLS_ILLEGAL);
		next_err[ERR_ACCESS] = acc_err_q;
		if (next_err != '0) begin
			next_result = '0;	// Nothing leaks on a fault
		end else if (op_class == CLS_MEMORY || op_class == CLS_PMEMORY) begin
			if (op_word_q.mem.write)
				next_result = {{(RES_W-DATA_W){1'b0}}, wdata};	// Store echoes B
			else
				next_result = {{(RES_W-DATA_W){1'b0}}, rdata};
		end else begin
			next_result = alu_res;	// Arithmetic and private
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
			access_en <= 1'b0;
			exec <= 1'b0;
			done <= 1'b0;
			acc_err_q <= 1'b0;
			result <= '0;
			err <= '0;
		end else begin
			access_en <= 1'b0;	// Strobes are single pulses
			exec <= 1'b0;
			done <= 1'b0;
			case (state)
				ST_IDLE, ST_DONE: state <= accept ? ST_DECODE : ST_IDLE;
				ST_DECODE: begin
					state <= ST_ACCESS;
					access_en <= 1'b1;	// Class settles during DECODE
				end
				ST_ACCESS: begin
					state <= ST_EXEC;
					exec <= 1'b1;
					acc_err_q <= access_err;	// Only valid while access_en
				end
				ST_EXEC: state <= ST_RESULT;	// ALU result lands here
				ST_RESULT: begin
					state <= ST_DONE;
					done <= 1'b1;
					result <= next_result;
					err <= next_err;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/secure_alu.sv
// Secure ALU top level
`timescale 1ns/1ps
`default_nettype none

module secure_alu
	import secure_alu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic [OP_W-1:0]   op,
	input  logic              op_pf,
	input  logic              sv,
	input  logic              start,
	output logic              done,
	output logic [RES_W-1:0]  result,
	output logic [ERR_W-1:0]  err,
	output logic              gp	// Any error flag
);

	op_word_u          op_word_q;
	logic              sv_q;
	logic              op_pf_q;
	logic [CLS_W-1:0]  op_class;
	logic [DATA_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              access_en;
	logic              access_err;
	logic              mem_we;
	logic              mem_re;
	logic [DATA_W-1:0] rdata;
	logic              exec;
	logic [DATA_W-1:0] alu_x;
	logic [RES_W-1:0]  alu_res;

	assign gp = |err;

	op_sequencer i_seq (
		.clk(clk), .reset_n(reset_n), .start(start),
		.a(a), .b(b), .op(op), .sv(sv), .op_pf(op_pf),
		.op_class(op_class), .access_err(access_err),
		.rdata(rdata), .alu_res(alu_res),
		.op_word_q(op_word_q), .sv_q(sv_q), .op_pf_q(op_pf_q),
		.addr(addr), .wdata(wdata), .access_en(access_en), .exec(exec),
		.alu_x(alu_x), .done(done), .result(result), .err(err)
	);

	// Decode works on the captured copy
	op_decoder i_dec (
		.op_word(op_word_q), .sv(sv_q), .op_pf(op_pf_q), .op_class(op_class)
	);

	access_ctrl i_acc (
		.access_en(access_en), .op_class(op_class), .op_word(op_word_q),
		.addr(addr), .mem_we(mem_we), .mem_re(mem_re), .access_err(access_err)
	);

	banked_mem i_mem (
		.clk(clk), .we(mem_we), .re(mem_re),
		.addr(addr), .wdata(wdata), .rdata(rdata)
	);

	// y is always operand B
	alu_core i_alu (
		.clk(clk), .reset_n(reset_n), .exec(exec), .op_word(op_word_q),
		.x(alu_x), .y(wdata), .res(alu_res)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset_n
);

	localparam int HALF_PERIOD = 5;	// 10 ns period
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/secure_alu_chk.sv
// Secure ALU protocol assertions
`timescale 1ns/1ps
`default_nettype none

module secure_alu_chk
	import secure_alu_pkg::*;
(
	input logic             clk,
	input logic             reset_n,
	input logic             start,
	input logic             done,
	input logic             mem_we,
	input logic             mem_re,
	input logic [ERR_W-1:0] err,
	input logic             gp
);

	logic [2:0] edges_left;	// Zero while the unit can take a start
	logic       accepted;

	assign accepted = start && (edges_left == 3'd0);

	// Counts down to the edge that raises done
	always_ff @(posedge clk) begin
		if (!reset_n)
			edges_left <= 3'd0;
		else if (accepted)
			edges_left <= 3'd4;
		else if (edges_left != 3'd0)
			edges_left <= edges_left - 3'd1;
	end

	done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(mem_we && mem_re))
		else $error("mem_we and mem_re high together");

	// Error flags only move on the edge that raises done
	err_held: assert property (@(posedge clk) disable iff (!reset_n)
		!done |-> $stable(err) && $stable(gp))
		else $error("err or gp changed without done");

	// Sampling edge plus four edges
	done_latency: assert property (@(posedge clk) disable iff (!reset_n)
		accepted |=> ##4 done)
		else $error("done missing four edges after an accepted start");

endmodule

`default_nettype wire

// File: verif/tb_secure_alu.sv
// Secure ALU testbench
`timescale 1ns/1ps
`default_nettype none

module tb_secure_alu
	import secure_alu_pkg::*;
();

	localparam int SEED = 33229;
	localparam int N_ARITH = 40;	// Random arithmetic ops
	localparam int N_PAIRS = 6;	// Random store/load pairs
	localparam int N_OPS = N_ARITH + 3 + 2 * (2 + N_PAIRS) + 11 + 6 + 10 + 2;
	localparam int MAX_CYCLES = 8 * N_OPS + 50;
	localparam logic [DATA_W-1:0] LOW_ADDR = 32'h0000_0010;
	localparam logic [DATA_W-1:0] HIGH_ADDR = 32'hFFFF_FF10;

	logic              clk;
	logic              reset_n;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [OP_W-1:0]   op;
	logic              op_pf;
	logic              sv;
	logic              start;
	logic              done;
	logic [RES_W-1:0]  result;
	logic [ERR_W-1:0]  err;
	logic              gp;

	logic [DATA_W-1:0] ref_low [MEM_DEPTH];	// Words written so far
	logic [DATA_W-1:0] ref_high [MEM_DEPTH];
	logic [RES_W-1:0]  exp_res_q [$];
	logic [ERR_W-1:0]  exp_err_q [$];
	int                due_q [$];	// Cycle where done must show
	int                cycle = 0;
	int                n_issued = 0;
	int                n_done = 0;
	int                due;

	tb_clock_gen i_clk (.clk(clk), .reset_n(reset_n));

	secure_alu i_dut (
		.clk(clk), .reset_n(reset_n), .a(a), .b(b), .op(op), .op_pf(op_pf),
		.sv(sv), .start(start), .done(done), .result(result), .err(err), .gp(gp)
	);

	bind secure_alu secure_alu_chk i_chk (
		.clk(clk), .reset_n(reset_n), .start(start), .done(done),
		.mem_we(mem_we), .mem_re(mem_re), .err(err), .gp(gp)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "Run stopped at first error");
	endtask

	function automatic logic [RES_W-1:0] zero_extend(input logic [DATA_W-1:0] v);
		return {{(RES_W-DATA_W){1'b0}}, v};
	endfunction

	// Expected result and err, memory model updated on stores
	function automatic logic [RES_W-1:0] ref_model(input logic [DATA_W-1:0] ra,
			input logic [DATA_W-1:0] rb, input logic [OP_W-1:0] rop, input logic rsv,
			input logic rpf, output logic [ERR_W-1:0] exp_err);
		logic              lo;
		logic              hi;
		logic [DATA_W-1:0] word;
		lo = (ra <= LOW_LIMIT);
		hi = (ra >= HIGH_BASE);
		exp_err = '0;
		ref_model = '0;
		word = hi ? ref_high[ra[MEM_AW-1:0]] : ref_low[ra[MEM_AW-1:0]];
		if (!rsv && !rpf && rop <= 8'h05) begin
			case (rop)
				OP_ADD: ref_model = zero_extend(ra) + zero_extend(rb);
				OP_SUB: ref_model = zero_extend(ra) - zero_extend(rb);	// Wraps at 2^64
				OP_MUL: ref_model = zero_extend(ra) * zero_extend(rb);
				OP_AND: ref_model = zero_extend(ra & rb);
				OP_OR: ref_model = zero_extend(ra | rb);
				default: ref_model = zero_extend(ra ^ rb);
			endcase
		end else if (!rsv && rpf && rop inside {8'h00, 8'h01, 8'h06, 8'h07}) begin
			// 06/07 need the upper window, bit 0 means store
			if ((rop >= 8'h06 && !hi) || (rop < 8'h06 && !lo)) begin
				exp_err[ERR_ACCESS] = 1'b1;
			end else if (rop[0]) begin
				if (hi)
					ref_high[ra[MEM_AW-1:0]] = rb;
				else
					ref_low[ra[MEM_AW-1:0]] = rb;
				ref_model = zero_extend(rb);	// Store echoes b
			end else begin
				ref_model = zero_extend(word);
			end
		end else if (rsv && rpf && rop inside {OP_NOT, OP_NOR, OP_NAND}) begin
			if (!lo && !hi)
				exp_err[ERR_ACCESS] = 1'b1;	// Gap between windows
			else if (rop == OP_NOT)
				ref_model = zero_extend(~word);
			else if (rop == OP_NOR)
				ref_model = zero_extend(~(word | rb));
			else
				ref_model = zero_extend(~(word & rb));
		end else begin
			exp_err[ERR_ILLEGAL] = 1'b1;
		end
	endfunction

	task automatic check_result(input logic [RES_W-1:0] got, input logic [RES_W-1:0] exp,
			input int idx);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: op %0d result 0x%h, expected 0x%h",
				$time, idx, got, exp));
	endtask

	task automatic check_err(input logic [ERR_W-1:0] got, input logic got_gp,
			input logic [ERR_W-1:0] exp, input int idx);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: op %0d err %b, expected %b",
				$time, idx, got, exp));
		else if (got_gp !== |exp)
			abort_run($sformatf("FAILED at %0t: op %0d gp %b, expected %b",
				$time, idx, got_gp, |exp));
	endtask

	// Called on a falling edge; returns on the falling edge that sees done
	task automatic issue_op(input logic [DATA_W-1:0] ta, input logic [DATA_W-1:0] tb_v,
			input logic [OP_W-1:0] top, input logic tsv, input logic tpf, input int hold);
		logic [RES_W-1:0] r;
		logic [ERR_W-1:0] e;
		logic [31:0]      rnd;
		r = ref_model(ta, tb_v, top, tsv, tpf, e);
		exp_res_q.push_back(r);
		exp_err_q.push_back(e);
		due_q.push_back(cycle + 5);	// Sampling edge, then four more
		n_issued++;
		a = ta;
		b = tb_v;
		op = top;
		sv = tsv;
		op_pf = tpf;
		start = 1'b1;
		repeat (hold) begin
			@(negedge clk);
			rnd = $urandom;
			a = rnd;	// Noise the busy unit must not capture
			b = ~rnd;
			op = rnd[OP_W-1:0];
		end
		@(negedge clk);
		start = 1'b0;
		while (!done)
			@(negedge clk);
	endtask

	task automatic random_arith();
		logic [31:0] rnd;
		issue_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, OP_ADD, 1'b0, 1'b0, 0);	// Carry out
		issue_op(32'h0, 32'h1, OP_SUB, 1'b0, 1'b0, 0);	// Borrow into upper half
		issue_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, OP_MUL, 1'b0, 1'b0, 0);
		repeat (N_ARITH) begin
			rnd = $urandom % 6;
			issue_op($urandom, $urandom, rnd[OP_W-1:0], 1'b0, 1'b0, 0);
		end
	endtask

	task automatic store_load_pairs();
		logic [31:0]       rnd;
		logic [DATA_W-1:0] addr;
		logic              hi;
		issue_op(LOW_ADDR, $urandom, 8'h01, 1'b0, 1'b1, 0);
		issue_op(LOW_ADDR, $urandom, 8'h00, 1'b0, 1'b1, 0);
		issue_op(HIGH_ADDR, $urandom, 8'h07, 1'b0, 1'b1, 0);
		issue_op(HIGH_ADDR, $urandom, 8'h06, 1'b0, 1'b1, 0);
		repeat (N_PAIRS) begin
			rnd = $urandom;
			hi = rnd[8];	// Random bank
			addr = hi ? {24'hFF_FFFF, rnd[7:0]} : {24'h00_0000, rnd[7:0]};
			issue_op(addr, $urandom, hi ? 8'h07 : 8'h01, 1'b0, 1'b1, 0);
			issue_op(addr, $urandom, hi ? 8'h06 : 8'h00, 1'b0, 1'b1, 0);
		end
	endtask

	task automatic window_violations();
		issue_op(HIGH_ADDR, 32'hDEAD_BEEF, 8'h01, 1'b0, 1'b1, 0);	// Public store, upper
		issue_op(LOW_ADDR, 32'hDEAD_BEEF, 8'h07, 1'b0, 1'b1, 0);	// Protected store, lower
		issue_op(32'h0000_1000, $urandom, 8'h00, 1'b0, 1'b1, 0);
		issue_op(32'h8000_0000, $urandom, 8'h07, 1'b0, 1'b1, 0);
		issue_op(32'h0001_0000, $urandom, OP_NOT, 1'b1, 1'b1, 0);
		// Window edges
		issue_op(32'h0000_00FF, $urandom, 8'h01, 1'b0, 1'b1, 0);
		issue_op(32'h0000_0100, $urandom, 8'h00, 1'b0, 1'b1, 0);
		issue_op(32'hFFFF_FEFF, $urandom, 8'h07, 1'b0, 1'b1, 0);
		issue_op(32'hFFFF_FF00, $urandom, 8'h07, 1'b0, 1'b1, 0);
		// Old words must survive the rejected stores
		issue_op(LOW_ADDR, $urandom, 8'h00, 1'b0, 1'b1, 0);
		issue_op(HIGH_ADDR, $urandom, 8'h06, 1'b0, 1'b1, 0);
	endtask

	task automatic private_ops();
		issue_op(LOW_ADDR, $urandom, OP_NOT, 1'b1, 1'b1, 0);
		issue_op(LOW_ADDR, $urandom, OP_NOR, 1'b1, 1'b1, 0);
		issue_op(LOW_ADDR, $urandom, OP_NAND, 1'b1, 1'b1, 0);
		issue_op(HIGH_ADDR, $urandom, OP_NOT, 1'b1, 1'b1, 0);
		issue_op(HIGH_ADDR, $urandom, OP_NOR, 1'b1, 1'b1, 0);
		issue_op(HIGH_ADDR, $urandom, OP_NAND, 1'b1, 1'b1, 0);
	endtask

	task automatic illegal_combos();
		issue_op($urandom, $urandom, 8'h06, 1'b0, 1'b0, 0);
		issue_op($urandom, $urandom, 8'h07, 1'b0, 1'b0, 0);
		issue_op(LOW_ADDR, $urandom, 8'h07, 1'b1, 1'b1, 0);	// Divide is gone
		issue_op($urandom, $urandom, 8'h0A, 1'b0, 1'b0, 0);
		issue_op(LOW_ADDR, $urandom, 8'h0A, 1'b0, 1'b1, 0);
		issue_op($urandom, $urandom, 8'h0A, 1'b1, 1'b0, 0);
		issue_op(LOW_ADDR, $urandom, 8'h0A, 1'b1, 1'b1, 0);
		issue_op($urandom, $urandom, 8'h00, 1'b1, 1'b0, 0);	// sv without prefix
		issue_op(LOW_ADDR, $urandom, 8'h02, 1'b0, 1'b1, 0);
		issue_op(LOW_ADDR, $urandom, 8'h00, 1'b1, 1'b1, 0);
	endtask

	// Start stays high through every busy state
	task automatic held_start();
		issue_op($urandom, $urandom, OP_MUL, 1'b0, 1'b0, 4);
		issue_op(LOW_ADDR, $urandom, 8'h00, 1'b0, 1'b1, 4);
		repeat (6) @(negedge clk);	// Room for a stray second done
	endtask

	// Cycle count and run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
			abort_run($sformatf("Timeout: no end of run after %0d cycles", cycle));
	end

	// Compare on the falling edge, outputs settled
	always @(negedge clk) begin
		if (reset_n && done) begin
			if (exp_res_q.size() == 0) begin
				abort_run("Done pulse seen with no operation in flight");
			end else begin
				check_result(result, exp_res_q.pop_front(), n_done);
				check_err(err, gp, exp_err_q.pop_front(), n_done);
				due = due_q.pop_front();
				if (cycle != due)
					abort_run($sformatf("FAILED at %0t: op %0d done at cycle %0d, expected %0d",
						$time, n_done, cycle, due));
				n_done++;
			end
		end
	end

	initial begin
		a = '0;
		b = '0;
		op = '0;
		op_pf = 1'b0;
		sv = 1'b0;
		start = 1'b0;
		void'($urandom(SEED));
		wait (reset_n);
		@(negedge clk);
		random_arith();
		store_load_pairs();
		window_violations();
		private_ops();
		illegal_combos();
		held_start();
		@(negedge clk);
		if (n_done == n_issued && exp_res_q.size() == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run($sformatf("Issued %0d operations but saw %0d done pulses",
				n_issued, n_done));
		end
	end

endmodule

`default_nettype wire

// File: list.f
design/secure_alu_pkg.sv
design/op_decoder.sv
design/access_ctrl.sv
design/banked_mem.sv
design/alu_core.sv
design/op_sequencer.sv
design/secure_alu.sv
verif/tb_clock_gen.sv
verif/secure_alu_chk.sv
verif/tb_secure_alu.sv

// File: Makefile
# Verilator build and run for the secure ALU

VERILATOR ?= verilator
TOP       ?= tb_secure_alu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG) || [ $$status -ne 0 ] || \
		! grep -q "Everything OK" $(LOG); then \
		echo "Simulation result: FAIL"; exit 1; \
	else \
		echo "Simulation result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
